/* id_ctrl_pkg.sv */
`default_nettype none

package id_ctrl_pkg;

  //////////////////////////////////////////////////
  // privilege and stage state encodings
  //////////////////////////////////////////////////

  // only user and machine mode are implemented
  typedef enum logic [1:0] {
    priv_lvl_u = 2'b00,
    priv_lvl_m = 2'b11
  } priv_lvl_e;

  // id/ex stage states
  typedef enum logic [1:0] {
    first_cycle  = 2'b00,
    multi_cycle  = 2'b01,
    second_cycle = 2'b10
  } id_fsm_e;

  typedef logic [4:0] reg_addr_t;

  //////////////////////////////////////////////////
  // decoder output
  //////////////////////////////////////////////////

  typedef struct packed {
    // instruction class
    logic      lsu_req;
    logic      lsu_we;
    logic      multdiv;
    logic      alu_multicycle;
    logic      branch;
    logic      jump;
    // jump target is valid this cycle
    logic      jump_set;
    // register file access
    logic      rf_we;
    logic      rf_ren_a;
    logic      rf_ren_b;
    reg_addr_t rf_raddr_a;
    reg_addr_t rf_raddr_b;
    // special instructions
    logic      illegal;
    logic      illegal_csr;
    logic      mret;
    logic      dret;
    logic      wfi;
  } dec_instr_t;

endpackage

`default_nettype wire

/* id_wb_pkg.sv */
`default_nettype none

package id_wb_pkg;

  //////////////////////////////////////////////////
  // writeback side view
  //////////////////////////////////////////////////

  // kind of instruction handed to writeback
  typedef enum logic [1:0] {
    wb_instr_load  = 2'b00,
    wb_instr_store = 2'b01,
    wb_instr_other = 2'b10
  } wb_instr_type_e;

  // state of the instruction sitting in writeback
  typedef struct packed {
    logic                  load_pending;
    logic                  store_pending;
    // memory response seen this cycle
    logic                  resp_valid;
    id_ctrl_pkg::reg_addr_t rf_waddr;
    // precise exception raised by writeback
    logic                  exception;
  } wb_status_t;

endpackage

`default_nettype wire

/* id_illegal_check.sv */
`timescale 1ns/1ns
`default_nettype none

module id_illegal_check (
  input  wire logic                   instr_valid_i,
  input  wire id_ctrl_pkg::dec_instr_t dec_i,
  input  wire id_ctrl_pkg::priv_lvl_e  priv_mode_i,
  input  wire logic                   debug_mode_i,
  input  wire logic                   csr_mstatus_tw_i,
  output logic                        illegal_o
);

  logic illegal_dret;
  logic illegal_umode;
  logic not_machine;

  // dret only allowed while in debug mode
  assign illegal_dret = dec_i.dret & ~debug_mode_i;

  assign not_machine = (priv_mode_i != id_ctrl_pkg::priv_lvl_m);

  // mret always machine only
  // wfi traps to machine mode when tw is set
  assign illegal_umode = not_machine &
                         (dec_i.mret | (csr_mstatus_tw_i & dec_i.wfi));

  // decoder and csr checks folded in here
  assign illegal_o = instr_valid_i &
                     (dec_i.illegal | dec_i.illegal_csr | illegal_dret | illegal_umode);

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // no flag on a bubble, kill logic downstream relies on it
  always_comb begin
    illegal_needs_valid_a: assert final (!illegal_o || instr_valid_i)
      else $error("illegal_o raised without a valid instruction");
  end

endmodule

`default_nettype wire

/* id_hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module id_hazard_unit (
  input  wire logic                   instr_valid_i,
  input  wire id_ctrl_pkg::dec_instr_t dec_i,
  input  wire id_wb_pkg::wb_status_t   wb_i,
  input  wire logic                   lsu_req_done_i,
  output logic                        stall_ld_hz_o,
  output logic                        stall_mem_o,
  output logic                        outstanding_access_o
);

  // read port addresses hit the writeback destination
  logic rd_a_wb_match;
  logic rd_b_wb_match;
  // match on a port that is really read
  logic rd_a_hz;
  logic rd_b_hz;
  logic outstanding;

  //////////////////////////////////////////////////
  // load-use hazard
  //////////////////////////////////////////////////

  // x0 never conflicts
  assign rd_a_wb_match = (dec_i.rf_raddr_a == wb_i.rf_waddr) & |dec_i.rf_raddr_a;
  assign rd_b_wb_match = (dec_i.rf_raddr_b == wb_i.rf_waddr) & |dec_i.rf_raddr_b;

  assign rd_a_hz = rd_a_wb_match & dec_i.rf_ren_a;
  assign rd_b_hz = rd_b_wb_match & dec_i.rf_ren_b;

  // load data comes too late to forward
  // hold in id until writeback drops the load
  assign stall_ld_hz_o = wb_i.load_pending & (rd_a_hz | rd_b_hz);

  //////////////////////////////////////////////////
  // memory stalls
  //////////////////////////////////////////////////

  // access in writeback with no response yet
  // an error response would make writeback trap precisely
  assign outstanding = (wb_i.load_pending | wb_i.store_pending) & ~wb_i.resp_valid;

  assign outstanding_access_o = outstanding;

  // also wait while the lsu request is not accepted yet
  // address calc must stay in id for that
  assign stall_mem_o = instr_valid_i &
                       (outstanding | (dec_i.lsu_req & ~lsu_req_done_i));

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // stores in writeback never cause a read hazard
  always_comb begin
    ld_hz_needs_load_a: assert final (wb_i.load_pending || !stall_ld_hz_o)
      else $error("load hazard flagged with no load in writeback");
  end

endmodule

`default_nettype wire

/* id_ex_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_fsm #(
  parameter bit branch_target_alu = 1'b0,
  parameter bit branch_predictor  = 1'b0
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      instr_valid_i,
  input  wire id_ctrl_pkg::dec_instr_t    dec_i,
  input  wire logic                      instr_fetch_err_i,
  input  wire logic                      wb_exception_i,
  input  wire logic                      illegal_i,
  input  wire logic                      stall_ld_hz_i,
  input  wire logic                      stall_mem_i,
  input  wire logic                      outstanding_access_i,
  input  wire logic                      branch_decision_i,
  input  wire logic                      ex_valid_i,
  input  wire logic                      ready_wb_i,
  output logic                           en_wb_o,
  output logic                           instr_id_done_o,
  output id_wb_pkg::wb_instr_type_e      instr_type_wb_o,
  output logic                           rf_we_o,
  output logic                           branch_set_o,
  output logic                           branch_not_set_o,
  output logic                           jump_set_o,
  output logic                           instr_first_cycle_o
);

  id_ctrl_pkg::id_fsm_e id_fsm_q;
  id_ctrl_pkg::id_fsm_e id_fsm_d;

  logic instr_kill;
  logic instr_executing;
  logic instr_executing_spec;
  logic multicycle_done;
  logic stall_multdiv;
  logic stall_alu;
  logic stall_branch;
  logic stall_jump;
  logic stall_id;
  logic branch_set_raw_d;
  logic branch_set_raw;
  logic jump_set_raw;
  logic set_done_q;
  logic set_done_d;

  //////////////////////////////////////////////////
  // execute qualifiers
  //////////////////////////////////////////////////

  // never executes, writeback will flush it
  assign instr_kill = instr_fetch_err_i | wb_exception_i | illegal_i;

  // spec version ignores wb outcome
  // keeps dmem errors off the branch/jump fetch path
  assign instr_executing_spec = instr_valid_i & ~instr_fetch_err_i & ~illegal_i &
                                ~stall_ld_hz_i;

  assign instr_executing = instr_valid_i & ~instr_kill & ~stall_ld_hz_i &
                           ~outstanding_access_i;

  // lsu finishes on request accept, others on ex_valid
  assign multicycle_done = dec_i.lsu_req ? ~stall_mem_i : ex_valid_i;

  //////////////////////////////////////////////////
  // stage state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= id_ctrl_pkg::first_cycle;
    end else if (instr_executing) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  always_comb begin
    id_fsm_d         = id_fsm_q;
    rf_we_o          = dec_i.rf_we;
    stall_multdiv    = 1'b0;
    stall_alu        = 1'b0;
    stall_branch     = 1'b0;
    stall_jump       = 1'b0;
    branch_set_raw_d = 1'b0;
    branch_not_set_o = 1'b0;
    jump_set_raw     = 1'b0;

    if (instr_executing_spec) begin
      unique case (id_fsm_q)
        id_ctrl_pkg::first_cycle: begin
          case (1'b1)
            dec_i.lsu_req: begin
              // request not taken yet, wait for it
              if (!stall_mem_i) begin
                id_fsm_d = id_ctrl_pkg::first_cycle;
              end else begin
                id_fsm_d = id_ctrl_pkg::multi_cycle;
              end
            end
            dec_i.multdiv: begin
              id_fsm_d      = id_ctrl_pkg::multi_cycle;
              rf_we_o       = 1'b0;
              stall_multdiv = 1'b1;
            end
            dec_i.branch: begin
              // decision only valid in first cycle
              id_fsm_d         = id_ctrl_pkg::second_cycle;
              stall_branch     = 1'b1;
              branch_set_raw_d = branch_decision_i;
              if (branch_predictor) begin
                branch_not_set_o = ~branch_decision_i;
              end
            end
            dec_i.jump: begin
              id_fsm_d     = id_ctrl_pkg::second_cycle;
              stall_jump   = 1'b1;
              jump_set_raw = dec_i.jump_set;
            end
            dec_i.alu_multicycle: begin
              id_fsm_d  = id_ctrl_pkg::multi_cycle;
              rf_we_o   = 1'b0;
              stall_alu = 1'b1;
            end
            default: begin
              id_fsm_d = id_ctrl_pkg::first_cycle;
            end
          endcase
        end

        id_ctrl_pkg::multi_cycle: begin
          // result written only once ex has it
          if (dec_i.multdiv | dec_i.alu_multicycle) begin
            rf_we_o = dec_i.rf_we & ex_valid_i;
          end
          if (multicycle_done & ready_wb_i) begin
            id_fsm_d = id_ctrl_pkg::first_cycle;
          end else begin
            stall_multdiv = dec_i.multdiv;
            stall_alu     = dec_i.alu_multicycle;
          end
        end

        id_ctrl_pkg::second_cycle: begin
          // branch/jump retires here, hold if wb busy
          if (ready_wb_i) begin
            id_fsm_d = id_ctrl_pkg::first_cycle;
          end
        end

        default: begin
          id_fsm_d = id_ctrl_pkg::first_cycle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // branch/jump set filter
  //////////////////////////////////////////////////

  if (branch_target_alu) begin : g_branch_set_direct
    // target ready same cycle as the decision
    assign branch_set_raw = branch_set_raw_d;
  end else begin : g_branch_set_flop
    logic branch_set_raw_q;

    // target computed by the alu next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        branch_set_raw_q <= 1'b0;
      end else begin
        branch_set_raw_q <= branch_set_raw_d;
      end
    end

    assign branch_set_raw = branch_set_raw_q;
  end

  // raw sets can repeat while spec runs but execute is held
  // only the first one leaves, flag drops on retire
  assign set_done_d = (branch_set_raw | jump_set_raw | set_done_q) & ~instr_id_done_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_done_q <= 1'b0;
    end else begin
      set_done_q <= set_done_d;
    end
  end

  assign branch_set_o = branch_set_raw & ~set_done_q;
  assign jump_set_o   = jump_set_raw & ~set_done_q;

  //////////////////////////////////////////////////
  // writeback handoff
  //////////////////////////////////////////////////

  assign stall_id = stall_ld_hz_i | stall_mem_i | stall_multdiv | stall_alu |
                    stall_branch | stall_jump;

  assign en_wb_o         = instr_executing & ~stall_id;
  assign instr_id_done_o = en_wb_o & ready_wb_i;

  assign instr_type_wb_o = !dec_i.lsu_req ? id_wb_pkg::wb_instr_other :
                           dec_i.lsu_we   ? id_wb_pkg::wb_instr_store :
                                            id_wb_pkg::wb_instr_load;

  // may stay in first cycle while stalled
  assign instr_first_cycle_o = instr_valid_i & (id_fsm_q == id_ctrl_pkg::first_cycle);

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  exec_implies_spec_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_executing |-> instr_executing_spec);

  // retiring past a wb trap would break precise exceptions
  done_no_wb_exc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_id_done_o |-> !wb_exception_i);

endmodule

`default_nettype wire

/* id_stage_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage_ctrl #(
  parameter bit branch_target_alu = 1'b0,
  parameter bit branch_predictor  = 1'b0
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // from if/id and decoder
  input  wire logic                      instr_valid_i,
  input  wire id_ctrl_pkg::dec_instr_t    dec_i,
  input  wire logic                      instr_fetch_err_i,
  // privilege and debug state
  input  wire id_ctrl_pkg::priv_lvl_e     priv_mode_i,
  input  wire logic                      debug_mode_i,
  input  wire logic                      csr_mstatus_tw_i,
  // ex and lsu
  input  wire logic                      branch_decision_i,
  input  wire logic                      ex_valid_i,
  input  wire logic                      lsu_req_done_i,
  // writeback
  input  wire id_wb_pkg::wb_status_t      wb_i,
  input  wire logic                      ready_wb_i,
  output logic                           illegal_insn_o,
  output logic                           en_wb_o,
  output logic                           instr_id_done_o,
  output id_wb_pkg::wb_instr_type_e      instr_type_wb_o,
  output logic                           rf_we_o,
  output logic                           branch_set_o,
  output logic                           branch_not_set_o,
  output logic                           jump_set_o,
  output logic                           instr_first_cycle_o
);

  logic stall_ld_hz;
  logic stall_mem;
  logic outstanding_access;

  // illegal flag also kills in the fsm
  id_illegal_check u_illegal_check (
    .instr_valid_i   (instr_valid_i),
    .dec_i           (dec_i),
    .priv_mode_i     (priv_mode_i),
    .debug_mode_i    (debug_mode_i),
    .csr_mstatus_tw_i(csr_mstatus_tw_i),
    .illegal_o       (illegal_insn_o)
  );

  id_hazard_unit u_hazard_unit (
    .instr_valid_i       (instr_valid_i),
    .dec_i               (dec_i),
    .wb_i                (wb_i),
    .lsu_req_done_i      (lsu_req_done_i),
    .stall_ld_hz_o       (stall_ld_hz),
    .stall_mem_o         (stall_mem),
    .outstanding_access_o(outstanding_access)
  );

  id_ex_fsm #(
    .branch_target_alu(branch_target_alu),
    .branch_predictor (branch_predictor)
  ) u_ex_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .dec_i               (dec_i),
    .instr_fetch_err_i   (instr_fetch_err_i),
    .wb_exception_i      (wb_i.exception),
    .illegal_i           (illegal_insn_o),
    .stall_ld_hz_i       (stall_ld_hz),
    .stall_mem_i         (stall_mem),
    .outstanding_access_i(outstanding_access),
    .branch_decision_i   (branch_decision_i),
    .ex_valid_i          (ex_valid_i),
    .ready_wb_i          (ready_wb_i),
    .en_wb_o             (en_wb_o),
    .instr_id_done_o     (instr_id_done_o),
    .instr_type_wb_o     (instr_type_wb_o),
    .rf_we_o             (rf_we_o),
    .branch_set_o        (branch_set_o),
    .branch_not_set_o    (branch_not_set_o),
    .jump_set_o          (jump_set_o),
    .instr_first_cycle_o (instr_first_cycle_o)
  );

endmodule

`default_nettype wire

/* tb_id_stage_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage_ctrl;

  // dut configuration that the expectations below follow
  localparam bit target_alu = 1'b0;
  localparam bit predictor  = 1'b1;
  // well above the length of all tests
  localparam int max_cycles = 400;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      instr_valid_i;
  id_ctrl_pkg::dec_instr_t   dec_i;
  logic                      instr_fetch_err_i;
  id_ctrl_pkg::priv_lvl_e    priv_mode_i;
  logic                      debug_mode_i;
  logic                      csr_mstatus_tw_i;
  logic                      branch_decision_i;
  logic                      ex_valid_i;
  logic                      lsu_req_done_i;
  id_wb_pkg::wb_status_t     wb_i;
  logic                      ready_wb_i;
  logic                      illegal_insn_o;
  logic                      en_wb_o;
  logic                      instr_id_done_o;
  id_wb_pkg::wb_instr_type_e instr_type_wb_o;
  logic                      rf_we_o;
  logic                      branch_set_o;
  logic                      branch_not_set_o;
  logic                      jump_set_o;
  logic                      instr_first_cycle_o;

  int errors = 0;
  int cycle_count = 0;
  int seed;

  id_stage_ctrl #(
    .branch_target_alu(target_alu),
    .branch_predictor (predictor)
  ) dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .dec_i              (dec_i),
    .instr_fetch_err_i  (instr_fetch_err_i),
    .priv_mode_i        (priv_mode_i),
    .debug_mode_i       (debug_mode_i),
    .csr_mstatus_tw_i   (csr_mstatus_tw_i),
    .branch_decision_i  (branch_decision_i),
    .ex_valid_i         (ex_valid_i),
    .lsu_req_done_i     (lsu_req_done_i),
    .wb_i               (wb_i),
    .ready_wb_i         (ready_wb_i),
    .illegal_insn_o     (illegal_insn_o),
    .en_wb_o            (en_wb_o),
    .instr_id_done_o    (instr_id_done_o),
    .instr_type_wb_o    (instr_type_wb_o),
    .rf_we_o            (rf_we_o),
    .branch_set_o       (branch_set_o),
    .branch_not_set_o   (branch_not_set_o),
    .jump_set_o         (jump_set_o),
    .instr_first_cycle_o(instr_first_cycle_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout after %0d cycles, tests did not complete", cycle_count);
      $display("errors: %0d", errors);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // expected values and reporting
  //////////////////////////////////////////////////

  // register actually read and written by the pending load
  function automatic logic load_use_rule(input id_ctrl_pkg::dec_instr_t d,
                                         input id_wb_pkg::wb_status_t w);
    logic hit_a;
    logic hit_b;
    hit_a = d.rf_ren_a & (d.rf_raddr_a == w.rf_waddr) & (d.rf_raddr_a != 5'd0);
    hit_b = d.rf_ren_b & (d.rf_raddr_b == w.rf_waddr) & (d.rf_raddr_b != 5'd0);
    return w.load_pending & (hit_a | hit_b);
  endfunction

  function automatic logic outstanding_rule(input id_wb_pkg::wb_status_t w);
    return (w.load_pending | w.store_pending) & ~w.resp_valid;
  endfunction

  // nonzero register index
  function automatic id_ctrl_pkg::reg_addr_t random_reg();
    logic [31:0] r;
    r = $random(seed);
    if (r[4:0] == 5'd0) begin
      return 5'd1;
    end
    return r[4:0];
  endfunction

  task automatic bit_error(input string name, input logic got, input logic exp);
    errors++;
    $display("Error: %s is %h, expected %h at cycle %0d", name, got, exp, cycle_count);
  endtask

  task automatic type_error(input logic [1:0] got, input logic [1:0] exp);
    errors++;
    $display("Error: instr_type_wb_o is %h, expected %h at cycle %0d", got, exp, cycle_count);
  endtask

  // drop the instruction for one cycle
  task automatic idle_cycle();
    instr_valid_i     = 1'b0;
    dec_i             = '0;
    branch_decision_i = 1'b0;
    ex_valid_i        = 1'b0;
    @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic illegal_case(input logic valid, input id_ctrl_pkg::dec_instr_t d,
                              input id_ctrl_pkg::priv_lvl_e priv, input logic dbg,
                              input logic exp);
    instr_valid_i = valid;
    dec_i         = d;
    priv_mode_i   = priv;
    debug_mode_i  = dbg;
    #1;
    if (illegal_insn_o !== exp) bit_error("illegal_insn_o", illegal_insn_o, exp);
    @(negedge clk_i);
  endtask

  task automatic illegal_rules();
    id_ctrl_pkg::dec_instr_t d_mret;
    id_ctrl_pkg::dec_instr_t d_wfi;
    id_ctrl_pkg::dec_instr_t d_dret;
    d_mret      = '0;
    d_mret.mret = 1'b1;
    d_wfi       = '0;
    d_wfi.wfi   = 1'b1;
    d_dret      = '0;
    d_dret.dret = 1'b1;
    // trap wfi in user mode
    csr_mstatus_tw_i = 1'b1;
    illegal_case(1'b1, d_mret, id_ctrl_pkg::priv_lvl_u, 1'b0, 1'b1);
    illegal_case(1'b1, d_wfi, id_ctrl_pkg::priv_lvl_u, 1'b0, 1'b1);
    illegal_case(1'b1, d_dret, id_ctrl_pkg::priv_lvl_u, 1'b0, 1'b1);
    illegal_case(1'b1, d_mret, id_ctrl_pkg::priv_lvl_m, 1'b0, 1'b0);
    illegal_case(1'b1, d_wfi, id_ctrl_pkg::priv_lvl_m, 1'b0, 1'b0);
    // bubbles never flag
    illegal_case(1'b0, d_mret, id_ctrl_pkg::priv_lvl_u, 1'b0, 1'b0);
    illegal_case(1'b0, d_dret, id_ctrl_pkg::priv_lvl_u, 1'b0, 1'b0);
    csr_mstatus_tw_i = 1'b0;
    priv_mode_i      = id_ctrl_pkg::priv_lvl_m;
    idle_cycle();
  endtask

  task automatic plain_retire();
    id_ctrl_pkg::dec_instr_t d;
    d            = '0;
    d.rf_we      = 1'b1;
    d.rf_ren_a   = 1'b1;
    d.rf_raddr_a = random_reg();
    instr_valid_i = 1'b1;
    dec_i         = d;
    #1;
    if (en_wb_o !== 1'b1) bit_error("en_wb_o", en_wb_o, 1'b1);
    if (instr_id_done_o !== 1'b1) bit_error("instr_id_done_o", instr_id_done_o, 1'b1);
    if (instr_type_wb_o !== id_wb_pkg::wb_instr_other)
      type_error(instr_type_wb_o, id_wb_pkg::wb_instr_other);
    @(negedge clk_i);
    // store whose request is accepted at once
    d              = '0;
    d.lsu_req      = 1'b1;
    d.lsu_we       = 1'b1;
    dec_i          = d;
    lsu_req_done_i = 1'b1;
    #1;
    if (en_wb_o !== 1'b1) bit_error("en_wb_o", en_wb_o, 1'b1);
    if (instr_id_done_o !== 1'b1) bit_error("instr_id_done_o", instr_id_done_o, 1'b1);
    if (instr_type_wb_o !== id_wb_pkg::wb_instr_store)
      type_error(instr_type_wb_o, id_wb_pkg::wb_instr_store);
    @(negedge clk_i);
    idle_cycle();
  endtask

  task automatic branch_two_cycle(input logic taken);
    id_ctrl_pkg::dec_instr_t d;
    d                 = '0;
    d.branch          = 1'b1;
    instr_valid_i     = 1'b1;
    dec_i             = d;
    branch_decision_i = taken;
    // first cycle with the decision known
    #1;
    if (en_wb_o !== 1'b0) bit_error("en_wb_o", en_wb_o, 1'b0);
    if (branch_set_o !== (taken & target_alu))
      bit_error("branch_set_o", branch_set_o, taken & target_alu);
    if (branch_not_set_o !== (predictor & ~taken))
      bit_error("branch_not_set_o", branch_not_set_o, predictor & ~taken);
    @(negedge clk_i);
    // second cycle retires
    #1;
    if (en_wb_o !== 1'b1) bit_error("en_wb_o", en_wb_o, 1'b1);
    if (instr_id_done_o !== 1'b1) bit_error("instr_id_done_o", instr_id_done_o, 1'b1);
    if (branch_set_o !== (taken & ~target_alu))
      bit_error("branch_set_o", branch_set_o, taken & ~target_alu);
    if (branch_not_set_o !== 1'b0) bit_error("branch_not_set_o", branch_not_set_o, 1'b0);
    @(negedge clk_i);
    instr_valid_i     = 1'b0;
    dec_i             = '0;
    branch_decision_i = 1'b0;
    // no repeat of the set
    repeat (2) begin
      #1;
      if (branch_set_o !== 1'b0) bit_error("branch_set_o", branch_set_o, 1'b0);
      @(negedge clk_i);
    end
  endtask

  // one cycle of a jump with its expected set and handoff
  task automatic jump_step(input logic exp_set, input logic exp_en);
    #1;
    if (jump_set_o !== exp_set) bit_error("jump_set_o", jump_set_o, exp_set);
    if (en_wb_o !== exp_en) bit_error("en_wb_o", en_wb_o, exp_en);
    @(negedge clk_i);
  endtask

  task automatic jump_once();
    id_ctrl_pkg::dec_instr_t d;
    id_wb_pkg::wb_status_t   w;
    d               = '0;
    d.jump          = 1'b1;
    d.jump_set      = 1'b1;
    w               = '0;
    w.store_pending = 1'b1;
    instr_valid_i   = 1'b1;
    dec_i           = d;
    // pending store holds execute while the target leaves only once
    wb_i = w;
    jump_step(1'b1, 1'b0);
    jump_step(1'b0, 1'b0);
    // store gone from writeback and the jump runs its two cycles
    wb_i = '0;
    jump_step(1'b0, 1'b0);
    jump_step(1'b0, 1'b1);
    // next jump gets its own set after the retire
    jump_step(1'b1, 1'b0);
    jump_step(1'b0, 1'b1);
    idle_cycle();
  endtask

  task automatic multicycle_backpressure();
    id_ctrl_pkg::dec_instr_t d;
    logic [4:0] ex_seq;
    logic [4:0] rdy_seq;
    logic       fin;
    int         i;
    // step i uses bit i
    ex_seq     = 5'b11100;
    rdy_seq    = 5'b10011;
    d          = '0;
    d.multdiv  = 1'b1;
    d.rf_we    = 1'b1;
    instr_valid_i = 1'b1;
    dec_i         = d;
    for (i = 0; i < 5; i++) begin
      ex_valid_i = ex_seq[i];
      ready_wb_i = rdy_seq[i];
      // ends only past the first cycle with both high
      fin = (i > 0) & ex_seq[i] & rdy_seq[i];
      #1;
      if (en_wb_o !== fin) bit_error("en_wb_o", en_wb_o, fin);
      if (instr_id_done_o !== fin) bit_error("instr_id_done_o", instr_id_done_o, fin);
      if (rf_we_o !== ((i > 0) & ex_seq[i])) bit_error("rf_we_o", rf_we_o, (i > 0) & ex_seq[i]);
      if (instr_first_cycle_o !== (i == 0))
        bit_error("instr_first_cycle_o", instr_first_cycle_o, i == 0);
      @(negedge clk_i);
    end
    ready_wb_i = 1'b1;
    idle_cycle();
  endtask

  // load waits, then its response shows, then it leaves writeback
  task automatic hazard_case(input id_ctrl_pkg::dec_instr_t d,
                             input id_ctrl_pkg::reg_addr_t waddr);
    id_wb_pkg::wb_status_t w;
    logic exp;
    int   ph;
    instr_valid_i = 1'b1;
    dec_i         = d;
    for (ph = 0; ph < 3; ph++) begin
      w              = '0;
      w.rf_waddr     = waddr;
      w.load_pending = (ph < 2);
      w.resp_valid   = (ph == 1);
      wb_i           = w;
      exp = ~load_use_rule(d, w) & ~outstanding_rule(w);
      #1;
      if (en_wb_o !== exp) bit_error("en_wb_o", en_wb_o, exp);
      @(negedge clk_i);
    end
    wb_i = '0;
    idle_cycle();
  endtask

  task automatic load_use_hazard();
    id_ctrl_pkg::dec_instr_t d;
    id_ctrl_pkg::reg_addr_t  a;
    // hit on port a
    a            = random_reg();
    d            = '0;
    d.rf_we      = 1'b1;
    d.rf_ren_a   = 1'b1;
    d.rf_raddr_a = a;
    hazard_case(d, a);
    // hit on port b
    a            = random_reg();
    d            = '0;
    d.rf_ren_b   = 1'b1;
    d.rf_raddr_b = a;
    hazard_case(d, a);
    // x0 never waits on a load
    d            = '0;
    d.rf_ren_a   = 1'b1;
    hazard_case(d, 5'd0);
    // address matches but port not read
    a            = random_reg();
    d            = '0;
    d.rf_raddr_a = a;
    hazard_case(d, a);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    seed              = 32'hedf8;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    dec_i             = '0;
    instr_fetch_err_i = 1'b0;
    priv_mode_i       = id_ctrl_pkg::priv_lvl_m;
    debug_mode_i      = 1'b0;
    csr_mstatus_tw_i  = 1'b0;
    branch_decision_i = 1'b0;
    ex_valid_i        = 1'b0;
    lsu_req_done_i    = 1'b0;
    wb_i              = '0;
    ready_wb_i        = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    if (en_wb_o !== 1'b0) bit_error("en_wb_o", en_wb_o, 1'b0);
    if (branch_set_o !== 1'b0) bit_error("branch_set_o", branch_set_o, 1'b0);
    if (jump_set_o !== 1'b0) bit_error("jump_set_o", jump_set_o, 1'b0);
    if (branch_not_set_o !== 1'b0) bit_error("branch_not_set_o", branch_not_set_o, 1'b0);
    if (instr_id_done_o !== 1'b0) bit_error("instr_id_done_o", instr_id_done_o, 1'b0);
    @(negedge clk_i);
    illegal_rules();
    plain_retire();
    branch_two_cycle(1'b1);
    branch_two_cycle(1'b0);
    jump_once();
    multicycle_backpressure();
    load_use_hazard();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
id_ctrl_pkg.sv
id_wb_pkg.sv
id_illegal_check.sv
id_hazard_unit.sv
id_ex_fsm.sv
id_stage_ctrl.sv
tb_id_stage_ctrl.sv

/* Makefile */
TOP = tb_id_stage_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
